// ==== sources.f ====
+incdir+verilog
verilog/core_pkg.sv
verilog/instr_issue.sv
verilog/decode_stage.sv
verilog/alu_stage.sv
verilog/mul_pipe.sv
verilog/writeback_regfile.sv
verilog/core_top.sv
test/core_asserts.sv
test/core_tb.sv

// ==== test/core_asserts.sv ====
`timescale 1ns/1ns

module core_asserts (
   input logic          clk,
   input logic          rst_n,
   input logic          instr_req,
   input logic          instr_ack,
   input core_pkg::wb_t alu_wb,
   input core_pkg::wb_t mul_wb
);

   // Ack only answers a pending request
   ack_rise: assert property (@(posedge clk) disable iff (!rst_n)
      $rose(instr_ack) |-> $past(instr_req))
      else $error("instr_ack rose while instr_req was low");

   // Ack drops only once the source has released req
   ack_fall: assert property (@(posedge clk) disable iff (!rst_n)
      $fell(instr_ack) |-> !$past(instr_req))
      else $error("instr_ack fell while instr_req was still high");

   // Writeback slot is never shared
   wb_single: assert property (@(posedge clk) disable iff (!rst_n)
      !(alu_wb.valid && mul_wb.valid))
      else $error("ALU and multiply results valid in the same cycle");

endmodule

bind core_top core_asserts asserts (
   .clk(clk),
   .rst_n(rst_n),
   .instr_req(instr_req),
   .instr_ack(instr_ack),
   .alu_wb(alu_wb),
   .mul_wb(mul_wb)
);

// ==== test/core_tb.sv ====
`timescale 1ns/1ns
`include "core_config.svh"

module core_tb;

   localparam int n_random    = 300;
   localparam int ack_limit   = 200;   // Cycles per handshake phase
   localparam int drain_limit = 500;

   logic                 clk;
   logic                 rst_n;
   logic                 instr_req;
   core_pkg::instr_t     instr;
   logic                 instr_ack;
   logic                 wb_valid;
   logic [`REG_ADDR-1:0] wb_rd;
   logic [`XLEN-1:0]     wb_data;
   logic [`REG_ADDR-1:0] dbg_addr;
   logic [`XLEN-1:0]     dbg_data;
   logic                 busy;

   logic [`XLEN-1:0] model_regs [`NREGS];   // Sequential reference state
   core_pkg::wb_t    pending [$];           // Expected writebacks, oldest first
   core_pkg::instr_t program_q [$];
   int               mismatches;
   int               other_errors;
   int               wb_count;

   core_top dut (
      .clk(clk), .rst_n(rst_n), .instr_req(instr_req), .instr(instr),
      .instr_ack(instr_ack), .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data),
      .dbg_addr(dbg_addr), .dbg_data(dbg_data), .busy(busy)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   task automatic check(input string name, input logic [`XLEN-1:0] got,
                        input logic [`XLEN-1:0] exp);
      if (got !== exp) begin
         mismatches++;
         $display("[FAIL] %0t ns %s: got %h, expected %h", $time, name, got, exp);
      end
   endtask

   function automatic core_pkg::instr_t make_instr(input core_pkg::opcode_e op,
         input logic [`REG_ADDR-1:0] rd, input logic [`REG_ADDR-1:0] rs1,
         input logic [5:0] low);
      core_pkg::instr_t ins;
      ins.opcode = op;
      ins.rd     = rd;
      ins.rs1    = rs1;
      ins.low    = low;
      return ins;
   endfunction

   // Mostly r0..r3 so hazards come often
   function automatic logic [`REG_ADDR-1:0] pick_reg();
      if ($urandom_range(0, 3) != 0)
         return `REG_ADDR'($urandom_range(0, 3));
      return `REG_ADDR'($urandom_range(0, `NREGS-1));
   endfunction

   function automatic core_pkg::instr_t random_instr();
      core_pkg::opcode_e op;
      case ($urandom_range(0, 11))
         0:       op = core_pkg::op_nop;
         1:       op = core_pkg::op_add;
         2:       op = core_pkg::op_sub;
         3:       op = core_pkg::op_and;
         4:       op = core_pkg::op_or;
         5:       op = core_pkg::op_xor;
         6, 7:    op = core_pkg::op_addi;
         default: op = core_pkg::op_mul;
      endcase
      return make_instr(op, pick_reg(), pick_reg(), {pick_reg(), 3'($urandom_range(0, 7))});
   endfunction

   // Executes one instruction in program order at handover
   task automatic model_issue(input core_pkg::instr_t ins);
      logic [`XLEN-1:0]   a;
      logic [`XLEN-1:0]   b;
      logic [`XLEN-1:0]   res;
      logic [2*`XLEN-1:0] prod;
      core_pkg::wb_t      exp_wb;
      a    = model_regs[ins.rs1];
      b    = model_regs[ins.low[5:3]];
      prod = a * b;
      case (ins.opcode)
         core_pkg::op_add:  res = a + b;
         core_pkg::op_sub:  res = a - b;
         core_pkg::op_and:  res = a & b;
         core_pkg::op_or:   res = a | b;
         core_pkg::op_xor:  res = a ^ b;
         core_pkg::op_addi: res = a + {{(`XLEN-6){ins.low[5]}}, ins.low};
         core_pkg::op_mul:  res = prod[`XLEN-1:0];
         default:           res = '0;
      endcase
      if (ins.opcode != core_pkg::op_nop && ins.rd != '0) begin
         model_regs[ins.rd] = res;
         exp_wb.valid = 1'b1;
         exp_wb.rd    = ins.rd;
         exp_wb.data  = res;
         pending.push_back(exp_wb);
      end
   endtask

   // One full four-phase exchange
   task automatic send(input core_pkg::instr_t ins, input int gap, output bit ok);
      int waited;
      ok = 1'b0;
      repeat (gap) @(posedge clk);
      @(posedge clk);
      instr     <= ins;
      instr_req <= 1'b1;
      waited = 0;
      @(negedge clk);
      while (!instr_ack && waited < ack_limit) begin
         @(negedge clk);
         waited++;
      end
      if (!instr_ack) begin
         other_errors++;
         $display("Timeout: instruction %h was never acknowledged", ins);
         return;
      end
      model_issue(ins);
      @(posedge clk);
      instr_req <= 1'b0;
      waited = 0;
      @(negedge clk);
      while (instr_ack && waited < ack_limit) begin
         @(negedge clk);
         waited++;
      end
      if (instr_ack) begin
         other_errors++;
         $display("Timeout: instr_ack stayed high after the request was dropped");
         return;
      end
      ok = 1'b1;
   endtask

   always @(negedge clk) begin : wb_monitor
      int idx;
      if (rst_n && wb_valid) begin
         wb_count++;
         idx = -1;
         for (int i = 0; i < pending.size(); i++)
            if (idx < 0 && pending[i].rd == wb_rd)
               idx = i;
         if (idx < 0) begin
            other_errors++;
            $display("Unexpected writeback to r%0d at %0t ns", wb_rd, $time);
         end else begin
            check("wb_data", wb_data, pending[idx].data);
            pending.delete(idx);
         end
      end
   end

   initial begin
      bit ok;
      int waited;
      int n_directed;
      rst_n        = 1'b0;
      instr_req    = 1'b0;
      instr        = '0;
      dbg_addr     = '0;
      mismatches   = 0;
      other_errors = 0;
      wb_count     = 0;
      for (int r = 0; r < `NREGS; r++)
         model_regs[r] = '0;
      void'($urandom(32'h45c07289));

      // Seed operands, then back-to-back multiplies, an r0 write and a nop
      program_q.push_back(make_instr(core_pkg::op_addi, 3'd1, 3'd0, 6'd13));
      program_q.push_back(make_instr(core_pkg::op_addi, 3'd2, 3'd0, 6'h39));
      program_q.push_back(make_instr(core_pkg::op_addi, 3'd3, 3'd0, 6'd29));
      program_q.push_back(make_instr(core_pkg::op_mul, 3'd4, 3'd1, {3'd2, 3'd0}));
      program_q.push_back(make_instr(core_pkg::op_mul, 3'd5, 3'd2, {3'd3, 3'd0}));
      program_q.push_back(make_instr(core_pkg::op_mul, 3'd6, 3'd3, {3'd1, 3'd0}));
      program_q.push_back(make_instr(core_pkg::op_mul, 3'd7, 3'd4, {3'd5, 3'd0}));
      program_q.push_back(make_instr(core_pkg::op_addi, 3'd0, 3'd1, 6'd5));
      program_q.push_back(make_instr(core_pkg::op_nop, 3'd3, 3'd1, 6'd0));
      n_directed = program_q.size();
      for (int n = 0; n < n_random; n++)
         program_q.push_back(random_instr());

      repeat (5) @(posedge clk);
      rst_n <= 1'b1;

      // Idle core straight out of reset
      @(negedge clk);
      check("instr_ack", instr_ack, '0);
      check("wb_valid", wb_valid, '0);
      check("busy", busy, '0);

      ok = 1'b1;
      for (int n = 0; n < program_q.size() && ok; n++)
         send(program_q[n], (n < n_directed) ? 0 : $urandom_range(0, 3), ok);

      if (ok) begin
         waited = 0;
         @(negedge clk);
         while (busy && waited < drain_limit) begin
            @(negedge clk);
            waited++;
         end
         if (busy) begin
            other_errors++;
            $display("Timeout: core still busy after the last instruction");
         end else begin
            check("wb_valid", wb_valid, '0);   // Nothing left on the wb port once idle
            @(posedge clk);
            if (pending.size() != 0) begin
               other_errors++;
               $display("%0d expected writebacks never arrived", pending.size());
            end
            for (int r = 0; r < `NREGS; r++) begin
               @(posedge clk);
               dbg_addr <= `REG_ADDR'(r);
               @(negedge clk);
               check($sformatf("dbg_data r%0d", r), dbg_data, model_regs[r]);
            end
         end
      end

      $display("Instructions %0d, writebacks %0d, mismatches %0d, other errors %0d",
               program_q.size(), wb_count, mismatches, other_errors);
      if (mismatches == 0 && other_errors == 0)
         $display("** PASS **");
      else
         $display("** FAIL **");
      $finish;
   end

endmodule

// ==== verilog/alu_stage.sv ====
`timescale 1ns/1ns
`include "core_config.svh"

module alu_stage (
   input  logic           clk,
   input  logic           rst_n,
   input  core_pkg::dec_t dec,
   output core_pkg::wb_t  alu_wb
);

   logic [`XLEN-1:0] result;
   logic             op_ok;   // Opcode handled by this path

   always_comb begin
      result = '0;
      op_ok  = 1'b1;
      case (dec.opcode)
         core_pkg::op_add:  result = dec.a + dec.b;
         core_pkg::op_addi: result = dec.a + dec.b;   // b holds the extended immediate
         core_pkg::op_sub:  result = dec.a - dec.b;
         core_pkg::op_and:  result = dec.a & dec.b;
         core_pkg::op_or:   result = dec.a | dec.b;
         core_pkg::op_xor:  result = dec.a ^ dec.b;
         default:           op_ok  = 1'b0;            // Nop, mul, unused codes
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         alu_wb <= '0;
      end else begin
         // Writes to r0 never reach writeback
         alu_wb.valid <= dec.valid && !dec.is_mul && op_ok && (dec.rd != '0);
         alu_wb.rd    <= dec.rd;
         alu_wb.data  <= result;
      end
   end

endmodule

// ==== verilog/core_config.svh ====
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// Datapath width in bits
`define XLEN 16

// Architectural registers, r0 hardwired to zero
`define NREGS 8

// Register address width, log2 of NREGS
`define REG_ADDR 3

`endif

// ==== verilog/core_pkg.sv ====
`include "core_config.svh"

package core_pkg;

   // 4-bit operation codes
   typedef enum logic [3:0] {
      op_nop  = 4'h0,
      op_add  = 4'h1,
      op_sub  = 4'h2,
      op_and  = 4'h3,
      op_or   = 4'h4,
      op_xor  = 4'h5,
      op_addi = 4'h6,
      op_mul  = 4'h7
   } opcode_e;

   // 16-bit instruction word
   typedef struct packed {
      opcode_e              opcode;
      logic [`REG_ADDR-1:0] rd;
      logic [`REG_ADDR-1:0] rs1;
      logic [5:0]           low;    // rs2 in 5:3, whole field is the addi immediate
   } instr_t;

   // Decode register contents
   typedef struct packed {
      logic                 valid;
      opcode_e              opcode;
      logic [`REG_ADDR-1:0] rd;
      logic [`XLEN-1:0]     a;
      logic [`XLEN-1:0]     b;      // rs2 value or extended immediate
      logic                 is_mul;
   } dec_t;

   // Result headed for writeback
   typedef struct packed {
      logic                 valid;
      logic [`REG_ADDR-1:0] rd;
      logic [`XLEN-1:0]     data;
   } wb_t;

endpackage

// ==== verilog/core_top.sv ====
`timescale 1ns/1ns
`include "core_config.svh"

module core_top (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 instr_req,
   input  core_pkg::instr_t     instr,
   output logic                 instr_ack,
   output logic                 wb_valid,
   output logic [`REG_ADDR-1:0] wb_rd,
   output logic [`XLEN-1:0]     wb_data,
   input  logic [`REG_ADDR-1:0] dbg_addr,
   output logic [`XLEN-1:0]     dbg_data,
   output logic                 busy
);

   // Issue register to decode
   logic                 issue_valid;
   core_pkg::instr_t     issue_instr;
   logic                 stall;

   // Operand reads
   logic [`REG_ADDR-1:0] rs1;
   logic [`REG_ADDR-1:0] rs2;
   logic [`XLEN-1:0]     rdata1;
   logic [`XLEN-1:0]     rdata2;

   core_pkg::dec_t       dec;
   core_pkg::wb_t        alu_wb;
   core_pkg::wb_t        mul_wb;
   core_pkg::wb_t [2:0]  mul_flight;   // Multiply stage destinations

   instr_issue issue (
      .clk(clk),
      .rst_n(rst_n),
      .instr_req(instr_req),
      .instr(instr),
      .instr_ack(instr_ack),
      .stall(stall),
      .issue_valid(issue_valid),
      .issue_instr(issue_instr)
   );

   decode_stage decode (
      .clk(clk),
      .rst_n(rst_n),
      .issue_valid(issue_valid),
      .issue_instr(issue_instr),
      .stall(stall),
      .rs1(rs1),
      .rs2(rs2),
      .rdata1(rdata1),
      .rdata2(rdata2),
      .alu_flight(alu_wb),
      .mul_flight(mul_flight),
      .dec(dec),
      .busy(busy)
   );

   alu_stage alu (
      .clk(clk),
      .rst_n(rst_n),
      .dec(dec),
      .alu_wb(alu_wb)
   );

   mul_pipe mul (
      .clk(clk),
      .rst_n(rst_n),
      .dec(dec),
      .mul_wb(mul_wb),
      .mul_flight(mul_flight)
   );

   writeback_regfile wb (
      .clk(clk),
      .rst_n(rst_n),
      .alu_wb(alu_wb),
      .mul_wb(mul_wb),
      .rs1(rs1),
      .rs2(rs2),
      .rdata1(rdata1),
      .rdata2(rdata2),
      .dbg_addr(dbg_addr),
      .dbg_data(dbg_data),
      .wb_valid(wb_valid),
      .wb_rd(wb_rd),
      .wb_data(wb_data)
   );

endmodule

// ==== verilog/decode_stage.sv ====
`timescale 1ns/1ns
`include "core_config.svh"

module decode_stage (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 issue_valid,
   input  core_pkg::instr_t     issue_instr,
   output logic                 stall,
   output logic [`REG_ADDR-1:0] rs1,
   output logic [`REG_ADDR-1:0] rs2,
   input  logic [`XLEN-1:0]     rdata1,
   input  logic [`XLEN-1:0]     rdata2,
   input  core_pkg::wb_t        alu_flight,
   input  core_pkg::wb_t [2:0]  mul_flight,
   output core_pkg::dec_t       dec,
   output logic                 busy
);

   // Decode register, ALU result and three multiply stages
   localparam int n_flight = 5;

   logic [`XLEN-1:0]                     imm;
   logic                                 is_mul;
   logic                                 is_imm;
   logic                                 uses_rs1;
   logic                                 uses_rs2;
   logic                                 writes_rd;
   logic [n_flight-1:0]                  fl_valid;
   logic [n_flight-1:0][`REG_ADDR-1:0]   fl_rd;
   logic                                 hazard;
   logic                                 slot_conflict;
   core_pkg::dec_t                       dec_next;

   assign rs1 = issue_instr.rs1;
   assign rs2 = issue_instr.low[5:3];
   assign imm = {{(`XLEN-6){issue_instr.low[5]}}, issue_instr.low};

   // Operand usage per opcode
   always_comb begin
      is_mul    = 1'b0;
      is_imm    = 1'b0;
      uses_rs1  = 1'b0;
      uses_rs2  = 1'b0;
      writes_rd = 1'b0;
      case (issue_instr.opcode)
         core_pkg::op_add, core_pkg::op_sub, core_pkg::op_and,
         core_pkg::op_or, core_pkg::op_xor: begin
            uses_rs1  = 1'b1;
            uses_rs2  = 1'b1;
            writes_rd = 1'b1;
         end
         core_pkg::op_addi: begin
            is_imm    = 1'b1;
            uses_rs1  = 1'b1;
            writes_rd = 1'b1;
         end
         core_pkg::op_mul: begin
            is_mul    = 1'b1;
            uses_rs1  = 1'b1;
            uses_rs2  = 1'b1;
            writes_rd = 1'b1;
         end
         default: ;   // Nop and unused codes touch nothing
      endcase
      if (issue_instr.rd == '0)
         writes_rd = 1'b0;
   end

   // Destinations still on their way to the register file
   assign fl_valid[0] = dec.valid && (dec.opcode != core_pkg::op_nop);
   assign fl_rd[0]    = dec.rd;
   assign fl_valid[1] = alu_flight.valid;
   assign fl_rd[1]    = alu_flight.rd;
   assign fl_valid[2] = mul_flight[0].valid;
   assign fl_rd[2]    = mul_flight[0].rd;
   assign fl_valid[3] = mul_flight[1].valid;
   assign fl_rd[3]    = mul_flight[1].rd;
   assign fl_valid[4] = mul_flight[2].valid;
   assign fl_rd[4]    = mul_flight[2].rd;

   // No forwarding, so any overlap with an in-flight write waits
   always_comb begin
      hazard = 1'b0;
      for (int i = 0; i < n_flight; i++) begin
         if (fl_valid[i] && (fl_rd[i] != '0)) begin
            if ((uses_rs1 && (fl_rd[i] == rs1)) ||
                (uses_rs2 && (fl_rd[i] == rs2)) ||
                (writes_rd && (fl_rd[i] == issue_instr.rd)))
               hazard = 1'b1;
         end
      end
   end

   // ALU result would land on the same cycle as the multiply now in stage 1
   assign slot_conflict = writes_rd && !is_mul && mul_flight[0].valid;

   assign stall = issue_valid && (hazard || slot_conflict);

   always_comb begin
      dec_next.valid  = issue_valid && !stall;
      dec_next.opcode = issue_instr.opcode;
      dec_next.rd     = issue_instr.rd;
      dec_next.a      = rdata1;
      dec_next.b      = is_imm ? imm : rdata2;
      dec_next.is_mul = is_mul;
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         dec <= '0;
      else
         dec <= dec_next;   // Bubble when stalled
   end

   assign busy = issue_valid || dec.valid || alu_flight.valid ||
                 mul_flight[0].valid || mul_flight[1].valid || mul_flight[2].valid;

endmodule

// ==== verilog/instr_issue.sv ====
`timescale 1ns/1ns

module instr_issue (
   input  logic             clk,
   input  logic             rst_n,
   input  logic             instr_req,
   input  core_pkg::instr_t instr,
   output logic             instr_ack,
   input  logic             stall,
   output logic             issue_valid,
   output core_pkg::instr_t issue_instr
);

   // Receiver side of the four-phase exchange
   typedef enum logic {
      hs_idle,   // Waiting for a request
      hs_ack     // Ack high, waiting for req to drop
   } hs_state_e;

   hs_state_e state;
   logic      take;

   // Accept only when the issue register is free or moving on this cycle
   assign take = instr_req && (state == hs_idle) && (!issue_valid || !stall);

   assign instr_ack = (state == hs_ack);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state       <= hs_idle;
         issue_valid <= 1'b0;
      end else begin
         case (state)
            hs_idle: if (take) state <= hs_ack;
            hs_ack:  if (!instr_req) state <= hs_idle;   // Req dropped, close the exchange
            default: state <= hs_idle;
         endcase

         if (take)
            issue_valid <= 1'b1;
         else if (!stall)
            issue_valid <= 1'b0;   // Moved into decode
      end
   end

   // Captured at the same edge that raises ack
   always_ff @(posedge clk) begin
      if (take)
         issue_instr <= instr;
   end

endmodule

// ==== verilog/mul_pipe.sv ====
`timescale 1ns/1ns
`include "core_config.svh"

module mul_pipe (
   input  logic                clk,
   input  logic                rst_n,
   input  core_pkg::dec_t      dec,
   output core_pkg::wb_t       mul_wb,
   output core_pkg::wb_t [2:0] mul_flight
);

   localparam int half = `XLEN / 2;

   // Stage 1 carries what stage 2 still needs from the operands
   typedef struct packed {
      core_pkg::wb_t   wb;      // data holds a times low byte of b
      logic [half-1:0] a_lo;
      logic [half-1:0] b_hi;
   } s1_t;

   s1_t              s1;
   core_pkg::wb_t    s2;
   logic [`XLEN-1:0] p_lo;
   logic [half-1:0]  p_hi;

   assign p_lo = dec.a * dec.b[half-1:0];   // Truncated to the low half of the product

   // Only the low byte of a times b_hi survives the shift by 8
   assign p_hi = s1.a_lo * s1.b_hi;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         s1     <= '0;
         s2     <= '0;
         mul_wb <= '0;
      end else begin
         s1.wb.valid <= dec.valid && dec.is_mul && (dec.rd != '0);
         s1.wb.rd    <= dec.rd;
         s1.wb.data  <= p_lo;
         s1.a_lo     <= dec.a[half-1:0];
         s1.b_hi     <= dec.b[`XLEN-1:half];

         s2.valid <= s1.wb.valid;
         s2.rd    <= s1.wb.rd;
         s2.data  <= s1.wb.data + {p_hi, {half{1'b0}}};

         mul_wb <= s2;   // Stage 3, low 16 bits of the product
      end
   end

   // Stage destinations for the hazard check
   assign mul_flight[0] = s1.wb;
   assign mul_flight[1] = s2;
   assign mul_flight[2] = mul_wb;

endmodule

// ==== verilog/writeback_regfile.sv ====
`timescale 1ns/1ns
`include "core_config.svh"

module writeback_regfile (
   input  logic                 clk,
   input  logic                 rst_n,
   input  core_pkg::wb_t        alu_wb,
   input  core_pkg::wb_t        mul_wb,
   input  logic [`REG_ADDR-1:0] rs1,
   input  logic [`REG_ADDR-1:0] rs2,
   output logic [`XLEN-1:0]     rdata1,
   output logic [`XLEN-1:0]     rdata2,
   input  logic [`REG_ADDR-1:0] dbg_addr,
   output logic [`XLEN-1:0]     dbg_data,
   output logic                 wb_valid,
   output logic [`REG_ADDR-1:0] wb_rd,
   output logic [`XLEN-1:0]     wb_data
);

   logic [`XLEN-1:0] regs [`NREGS];
   core_pkg::wb_t    wb_sel;

   // Decode keeps the two paths apart, so at most one is valid
   assign wb_sel = alu_wb.valid ? alu_wb : mul_wb;

   assign wb_valid = wb_sel.valid;
   assign wb_rd    = wb_sel.rd;
   assign wb_data  = wb_sel.data;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < `NREGS; i++)
            regs[i] <= '0;
      end else if (wb_sel.valid && (wb_sel.rd != '0)) begin
         regs[wb_sel.rd] <= wb_sel.data;   // End of the wb cycle
      end
   end

   // r0 hardwired to zero on every read port
   assign rdata1   = (rs1 == '0) ? '0 : regs[rs1];
   assign rdata2   = (rs2 == '0) ? '0 : regs[rs2];
   assign dbg_data = (dbg_addr == '0) ? '0 : regs[dbg_addr];

endmodule
